//--- hw/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Datapath width in bits
`define MIPS_XLEN 32

// Architectural register count
`define MIPS_NREGS 32

// Data memory depth in 32-bit words
`define MIPS_DMEM_WORDS 64

// PC value loaded by reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

//--- hw/mips_pkg.sv
`include "mips_settings.svh"

package mips_pkg;

    localparam int XLEN   = `MIPS_XLEN;
    localparam int REG_AW = $clog2(`MIPS_NREGS);

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_RTYPE = 4'b0000, // Operation taken from funct
        ALU_ADD   = 4'b0001,
        ALU_ADDU  = 4'b0010,
        ALU_AND   = 4'b0011,
        ALU_XOR   = 4'b0100,
        ALU_OR    = 4'b0101,
        ALU_SLT   = 4'b0110,
        ALU_LUI   = 4'b0111,
        ALU_SUB   = 4'b1000  // Compare for BEQ/BNE
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'b000,
        BR_BGEZ = 3'b001,
        BR_BEQ  = 3'b100,
        BR_BNE  = 3'b101,
        BR_BLEZ = 3'b110,
        BR_BGTZ = 3'b111
    } branch_e;

    typedef struct packed {
        logic       reg_dst;
        logic [1:0] alu_src;  // [0] picks shamt for a, [1] picks imm for b
        logic       mem_to_reg;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       is_lb_sb;
        branch_e    branch;
        alu_op_e    alu_op;
        logic       jr;
        logic [1:0] jump;     // 01 j, 10 jal
        logic       do_extend;
    } ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [5:0]  funct;
        logic [4:0]  shamt;
        logic [15:0] imm;
        logic [25:0] jidx;
        word_t       rs_val;
        word_t       rt_val;
        reg_idx_t    dest;
    } dec_payload_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dest;
        word_t    next_pc;
    } exe_payload_t;

endpackage

//--- hw/stage_if.sv
`timescale 1ns/1ps

// Registered hop between two pipeline stages
interface stage_if #(
    parameter type payload_t = logic
);

    logic     valid;
    payload_t payload;

    modport sender (
        output valid,
        output payload
    );

    modport receiver (
        input valid,
        input payload
    );

endinterface

//--- hw/control.sv
`timescale 1ns/1ps

module control
    import mips_pkg::*;
#(
    parameter int OPCODE_LENGTH = 6,
    parameter int FUNCT_LENGTH  = 6
) (
    input  logic [OPCODE_LENGTH-1:0] opcode,
    input  logic [FUNCT_LENGTH-1:0]  func,
    output ctrl_t                    ctrl,
    output logic                     cache_en
);

    assign cache_en = ctrl.mem_read || ctrl.mem_write;

    always_comb begin
        ctrl           = '0;
        ctrl.do_extend = 1'b1;
        casez (opcode)
            6'b000000: begin // R-type
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (func)
                    6'b000000, 6'b000010, 6'b000011: begin
                        ctrl.alu_src[0] = 1'b1; // Shift by shamt
                    end
                    6'b001000: begin
                        ctrl.jr = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            6'b001000: begin // ADDi
                ctrl.alu_src   = 2'b10;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            6'b001001: begin // ADDiu
                ctrl.alu_src   = 2'b10;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_ADDU;
                ctrl.do_extend = 1'b0;
            end
            6'b001100: begin // ANDi
                ctrl.alu_src   = 2'b10;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_AND;
                ctrl.do_extend = 1'b0;
            end
            6'b001110: begin // XORi
                ctrl.alu_src   = 2'b10;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_XOR;
                ctrl.do_extend = 1'b0;
            end
            6'b001101: begin // ORi
                ctrl.alu_src   = 2'b10;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_OR;
                ctrl.do_extend = 1'b0;
            end
            6'b001010: begin // SLTi
                ctrl.alu_src   = 2'b10;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_SLT;
            end
            6'b001111: begin // Lui
                ctrl.alu_src   = 2'b10;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_LUI;
            end
            6'b0001??: begin // BEQ, BNE, BLEZ, BGTZ
                ctrl.branch = branch_e'(opcode[2:0]);
                ctrl.alu_op = ALU_SUB;
            end
            6'b000001: begin // BGEZ
                ctrl.branch = BR_BGEZ;
            end
            6'b000010: begin // j
                ctrl.jump = 2'b01;
            end
            6'b000011: begin // jal
                ctrl.jump      = 2'b10;
                ctrl.reg_write = 1'b1;
            end
            6'b100011, 6'b100000: begin // LW, LB
                ctrl.alu_src    = 2'b10;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = ALU_ADD;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.is_lb_sb   = !opcode[1];
            end
            6'b101011, 6'b101000: begin // SW, SB
                ctrl.alu_src   = 2'b10;
                ctrl.alu_op    = ALU_ADD;
                ctrl.mem_write = 1'b1;
                ctrl.is_lb_sb  = !opcode[1];
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module decode_stage
    import mips_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic [31:0]    instr,
    input  logic           rf_we,
    input  reg_idx_t       rf_waddr,
    input  word_t          rf_wdata,
    stage_if.sender        dec_bus
);

    ctrl_t        ctrl;
    logic         cache_en;
    reg_idx_t     rs;
    reg_idx_t     rt;
    reg_idx_t     rd;
    word_t        regs [`MIPS_NREGS];
    dec_payload_t dec_d;

    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    control #(
        .OPCODE_LENGTH(6),
        .FUNCT_LENGTH (6)
    ) u_control (
        .opcode  (instr[31:26]),
        .func    (instr[5:0]),
        .ctrl    (ctrl),
        .cache_en(cache_en)
    );

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    always_comb begin
        dec_d                = '0;
        dec_d.ctrl           = ctrl;
        dec_d.ctrl.mem_read  = ctrl.mem_read && cache_en; // Data memory enable
        dec_d.ctrl.mem_write = ctrl.mem_write && cache_en;
        dec_d.funct          = instr[5:0];
        dec_d.shamt          = instr[10:6];
        dec_d.imm            = instr[15:0];
        dec_d.jidx           = instr[25:0];
        dec_d.rs_val         = (rs == '0) ? '0 : regs[rs];
        dec_d.rt_val         = (rt == '0) ? '0 : regs[rt];
        if (ctrl.jump == 2'b10) begin
            dec_d.dest = reg_idx_t'(31); // Link register
        end else if (ctrl.reg_dst) begin
            dec_d.dest = rd;
        end else begin
            dec_d.dest = rt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_bus.valid <= 1'b0;
        end else begin
            dec_bus.valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dec_bus.payload <= dec_d;
        end
    end

    // One instruction in flight at a time
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        dec_bus.valid |-> !start);

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module execute_stage
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    stage_if.receiver dec_bus,
    stage_if.sender   exe_bus
);

    dec_payload_t d;
    exe_payload_t exe_d;
    word_t        pc;
    word_t        pc_plus4;
    word_t        imm_ext;
    word_t        br_offset;
    word_t        op_a;
    word_t        op_b;
    word_t        alu_result;
    word_t        next_pc;
    logic         zero;
    logic         taken;

    assign d         = dec_bus.payload;
    assign pc_plus4  = pc + word_t'(4);
    assign imm_ext   = d.ctrl.do_extend ? {{(XLEN-16){d.imm[15]}}, d.imm}
                                        : {{(XLEN-16){1'b0}}, d.imm};
    assign br_offset = {{(XLEN-18){d.imm[15]}}, d.imm, 2'b00};
    assign op_a      = d.ctrl.alu_src[0] ? word_t'(d.shamt) : d.rs_val;
    assign op_b      = d.ctrl.alu_src[1] ? imm_ext : d.rt_val;
    assign zero      = (alu_result == '0);

    always_comb begin
        case (d.ctrl.alu_op)
            ALU_ADD, ALU_ADDU: alu_result = op_a + op_b;
            ALU_AND:           alu_result = op_a & op_b;
            ALU_XOR:           alu_result = op_a ^ op_b;
            ALU_OR:            alu_result = op_a | op_b;
            ALU_SLT:           alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_LUI:           alu_result = op_b << 16;
            ALU_SUB:           alu_result = op_a - op_b;
            default: begin
                case (d.funct)
                    6'b100000, 6'b100001: alu_result = op_a + op_b;
                    6'b100010: alu_result = op_a - op_b;
                    6'b100100: alu_result = op_a & op_b;
                    6'b100101: alu_result = op_a | op_b;
                    6'b100110: alu_result = op_a ^ op_b;
                    6'b101010: alu_result = word_t'($signed(op_a) < $signed(op_b));
                    6'b000000: alu_result = op_b << op_a[4:0];
                    6'b000010: alu_result = op_b >> op_a[4:0];
                    6'b000011: alu_result = word_t'($signed(op_b) >>> op_a[4:0]);
                    default:   alu_result = op_a + op_b;
                endcase
            end
        endcase
    end

    always_comb begin
        case (d.ctrl.branch)
            BR_BEQ:  taken = zero;
            BR_BNE:  taken = !zero;
            BR_BLEZ: taken = ($signed(d.rs_val) <= 0);
            BR_BGTZ: taken = ($signed(d.rs_val) > 0);
            BR_BGEZ: taken = !d.rs_val[XLEN-1];
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (d.ctrl.jr) begin
            next_pc = d.rs_val;
        end else if (d.ctrl.jump != 2'b00) begin
            next_pc = {pc_plus4[XLEN-1:XLEN-4], d.jidx, 2'b00};
        end else if (taken) begin
            next_pc = pc_plus4 + br_offset;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        exe_d            = '0;
        exe_d.ctrl       = d.ctrl;
        exe_d.alu_result = (d.ctrl.jump == 2'b10) ? pc_plus4 : alu_result; // jal link
        exe_d.store_data = d.rt_val;
        exe_d.dest       = d.dest;
        exe_d.next_pc    = next_pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc            <= `MIPS_RESET_PC;
            exe_bus.valid <= 1'b0;
        end else begin
            exe_bus.valid <= dec_bus.valid;
            if (dec_bus.valid) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_bus.valid) begin
            exe_bus.payload <= exe_d;
        end
    end

    a_one_pc_source: assert property (@(posedge clk) disable iff (rst)
        dec_bus.valid |-> !(d.ctrl.jr && d.ctrl.jump != 2'b00));

endmodule

//--- hw/result_stage.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module result_stage
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    stage_if.receiver exe_bus,
    output logic      rf_we,
    output reg_idx_t  rf_waddr,
    output word_t     rf_wdata,
    output logic      done,
    output logic      wb_en,
    output reg_idx_t  wb_reg,
    output word_t     wb_data,
    output logic      store_en,
    output word_t     store_addr,
    output word_t     store_data,
    output word_t     next_pc
);

    localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

    exe_payload_t       res;
    logic               res_valid;
    word_t              dmem [`MIPS_DMEM_WORDS];
    logic [DMEM_AW-1:0] word_addr;
    logic [1:0]         lane;
    word_t              rd_word;
    logic [7:0]         rd_byte;
    word_t              load_val;
    word_t              wb_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= exe_bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_bus.valid) begin
            res <= exe_bus.payload;
        end
    end

    assign word_addr = res.alu_result[DMEM_AW+1:2];
    assign lane      = res.alu_result[1:0];
    assign rd_word   = dmem[word_addr];
    assign rd_byte   = rd_word[{lane, 3'b000} +: 8];
    assign load_val  = res.ctrl.is_lb_sb ? {{(XLEN-8){rd_byte[7]}}, rd_byte} : rd_word;
    assign wb_value  = res.ctrl.mem_to_reg ? load_val : res.alu_result;

    // Register 0 is never written
    assign rf_we    = res_valid && res.ctrl.reg_write && (res.dest != '0);
    assign rf_waddr = res.dest;
    assign rf_wdata = wb_value;

    always_ff @(posedge clk) begin
        if (res_valid && res.ctrl.mem_write) begin
            if (res.ctrl.is_lb_sb) begin
                dmem[word_addr][{lane, 3'b000} +: 8] <= res.store_data[7:0]; // SB lane
            end else begin
                dmem[word_addr] <= res.store_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done     <= 1'b0;
            wb_en    <= 1'b0;
            store_en <= 1'b0;
        end else begin
            done <= res_valid;
            if (res_valid) begin
                wb_en    <= rf_we;
                store_en <= res.ctrl.mem_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            wb_reg     <= res.dest;
            wb_data    <= wb_value;
            store_addr <= res.alu_result;
            store_data <= res.store_data;
            next_pc    <= res.next_pc;
        end
    end

endmodule

//--- hw/mips_exec_top.sv
`timescale 1ns/1ps

module mips_exec_top
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic [31:0] instr,
    output logic        ack,
    output word_t       next_pc,
    output logic        wb_en,
    output reg_idx_t    wb_reg,
    output word_t       wb_data,
    output logic        store_en,
    output word_t       store_addr,
    output word_t       store_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_WAIT_REL
    } seq_state_e;

    seq_state_e state;
    logic       start;
    logic       done;
    logic       rf_we;
    reg_idx_t   rf_waddr;
    word_t      rf_wdata;

    stage_if #(.payload_t(dec_payload_t)) dec_bus ();
    stage_if #(.payload_t(exe_payload_t)) exe_bus ();

    assign ack = done || (state == S_WAIT_REL); // Held while host keeps req

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req && !ack) begin
                        state <= S_BUSY;
                        start <= 1'b1;
                    end
                end
                S_BUSY: begin
                    if (done) begin
                        state <= req ? S_WAIT_REL : S_IDLE;
                    end
                end
                S_WAIT_REL: begin
                    if (!req) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    decode_stage u_decode (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .instr   (instr),
        .rf_we   (rf_we),
        .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata),
        .dec_bus (dec_bus.sender)
    );

    execute_stage u_execute (
        .clk    (clk),
        .rst    (rst),
        .dec_bus(dec_bus.receiver),
        .exe_bus(exe_bus.sender)
    );

    result_stage u_result (
        .clk       (clk),
        .rst       (rst),
        .exe_bus   (exe_bus.receiver),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .done      (done),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .store_en  (store_en),
        .store_addr(store_addr),
        .store_data(store_data),
        .next_pc   (next_pc)
    );

    // Four-phase release
    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req));

endmodule

//--- testbench/tb_mips_tests.svh
function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] jtype_word(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
endfunction

// Full 32-bit constant through Lui and ORi
task load_reg(input logic [4:0] r, input logic [31:0] val);
    run_instr(itype_word(6'h0f, 5'd0, r, val[31:16]), "lui");
    run_instr(itype_word(6'h0d, r, r, val[15:0]), "ori");
endtask

task handshake_test();
    logic [31:0] w;
    check(ack, 1'b0, "ack low after reset");
    w = itype_word(6'h08, 5'd0, 5'd25, 16'h0123);
    model_step(w);
    send_instr(w, 5);
    compare_outputs("addi with held req");
    run_instr(itype_word(6'h08, 5'd25, 5'd26, 16'hfff1), "addi after release");
endtask

task imm_ops_test();
    logic [5:0]  ops [6];
    logic [15:0] imm;
    int          k;
    int          neg;
    ops = '{6'h08, 6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0a};
    k   = 1;
    for (neg = 0; neg < 2; neg++) begin
        foreach (ops[i]) begin
            imm     = 16'($urandom);
            imm[15] = neg[0]; // Second pass uses negative immediates
            run_instr(itype_word(ops[i], 5'(k - 1), 5'(k), imm),
                      $sformatf("imm op %h", ops[i]));
            k++;
        end
    end
    run_instr(itype_word(6'h0f, 5'd0, 5'd20, 16'($urandom)), "lui");
endtask

task rtype_test();
    logic [5:0] alu_fn [7];
    logic [5:0] sh_fn [3];
    alu_fn = '{6'h20, 6'h21, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2a};
    sh_fn  = '{6'h00, 6'h02, 6'h03};
    load_reg(5'd1, $urandom);
    load_reg(5'd2, $urandom);
    load_reg(5'd3, $urandom | 32'h8000_0000); // Negative for sra
    foreach (alu_fn[i]) begin
        run_instr(rtype_word(alu_fn[i], 5'd1, 5'd2, 5'(8 + i), 5'd0),
                  $sformatf("rtype %h", alu_fn[i]));
    end
    foreach (sh_fn[i]) begin
        run_instr(rtype_word(sh_fn[i], 5'd0, 5'd3, 5'(16 + i), 5'($urandom)),
                  $sformatf("shift %h", sh_fn[i]));
    end
    run_instr(rtype_word(6'h20, 5'd1, 5'd2, 5'd0, 5'd0), "add to r0");
    check(wb_en, 1'b0, "write to r0 shows wb_en low");
endtask

task memory_test();
    logic [31:0] val;
    int          lane;
    load_reg(5'd4, 32'h0000_0040); // Base address
    val = $urandom;
    load_reg(5'd5, val);
    run_instr(itype_word(6'h2b, 5'd4, 5'd5, 16'h0008), "sw");
    check(store_en, 1'b1, "sw store_en");
    run_instr(itype_word(6'h23, 5'd4, 5'd6, 16'h0008), "lw");
    check(wb_data, val, "lw returns stored word");
    run_instr(itype_word(6'h2b, 5'd4, 5'd5, 16'h000c), "sw before sb");
    for (lane = 0; lane < 4; lane++) begin
        val    = $urandom;
        val[7] = lane[0];
        load_reg(5'd7, val);
        run_instr(itype_word(6'h28, 5'd4, 5'd7, 16'(12 + lane)), "sb");
        run_instr(itype_word(6'h20, 5'd4, 5'd8, 16'(12 + lane)), "lb");
        check(wb_data, {{24{val[7]}}, val[7:0]}, "lb sign-extended byte");
    end
endtask

task branch_test();
    logic [5:0]  op [10];
    logic [4:0]  rs [10];
    logic [4:0]  rt [10];
    logic [31:0] val;
    logic [31:0] pc4;
    op  = '{6'h04, 6'h04, 6'h05, 6'h05, 6'h06, 6'h06, 6'h07, 6'h07, 6'h01, 6'h01};
    rs  = '{5'd10, 5'd10, 5'd10, 5'd10, 5'd12, 5'd10, 5'd10, 5'd12, 5'd10, 5'd12};
    rt  = '{5'd11, 5'd12, 5'd12, 5'd11, 5'd0, 5'd0, 5'd0, 5'd0, 5'd1, 5'd1};
    val = ($urandom & 32'h7fff_ffff) | 32'd1; // Positive and nonzero
    load_reg(5'd10, val);
    load_reg(5'd11, val);
    load_reg(5'd12, $urandom | 32'h8000_0000);
    foreach (op[i]) begin
        pc4 = m_pc + 32'd4;
        run_instr(itype_word(op[i], rs[i], rt[i], 16'($urandom) | 16'h0001),
                  $sformatf("branch %h", op[i]));
        check(next_pc != pc4, !i[0], "branch taken on even entries only");
    end
endtask

task jump_test();
    logic [31:0] target;
    logic [31:0] link;
    run_instr(jtype_word(6'h02, 26'($urandom)), "j");
    target = $urandom & 32'hffff_fffc;
    load_reg(5'd13, target);
    run_instr(rtype_word(6'h08, 5'd13, 5'd0, 5'd0, 5'd0), "jr");
    check(next_pc, target, "jr target");
    link = m_pc + 32'd4;
    run_instr(jtype_word(6'h03, 26'($urandom)), "jal");
    check(wb_reg, 32'd31, "jal link register");
    check(wb_data, link, "jal link value");
    run_instr(rtype_word(6'h08, 5'd31, 5'd0, 5'd0, 5'd0), "jr r31");
    check(next_pc, link, "return through r31");
endtask

//--- testbench/tb_mips_exec.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_mips_exec;

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] instr;
    logic        ack;
    logic [31:0] next_pc;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic        store_en;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    // Reference model state
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [`MIPS_DMEM_WORDS];
    logic [31:0] m_pc;

    // Expected port values of the last modelled instruction
    logic        exp_wb_en;
    logic [4:0]  exp_wb_reg;
    logic [31:0] exp_wb_data;
    logic        exp_store_en;
    logic [31:0] exp_store_addr;
    logic [31:0] exp_store_data;
    logic [31:0] exp_next_pc;

    mips_exec_top dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .instr     (instr),
        .ack       (ack),
        .next_pc   (next_pc),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .store_en  (store_en),
        .store_addr(store_addr),
        .store_data(store_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task check(input logic [31:0] actual, input logic [31:0] expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task report_timeout(input string what);
        $display("Timeout: %s within 20 cycles", what);
        $display("Errors found");
        $fatal(1);
    endtask

    // Four-phase exchange that may hold req after ack
    task send_instr(input logic [31:0] word, input int hold);
        int          n;
        logic [31:0] held_pc;
        instr = word;
        req   = 1'b1;
        n     = 0;
        while (ack !== 1'b1) begin
            @(posedge clk);
            #1;
            n++;
            if (n >= 20) report_timeout("ack did not rise after req");
        end
        held_pc = next_pc;
        repeat (hold) begin
            @(posedge clk);
            #1;
            check(ack, 1'b1, "ack held while req high");
            check(next_pc, held_pc, "no new instruction while req held");
        end
        req = 1'b0;
        n   = 0;
        while (ack !== 1'b0) begin
            @(posedge clk);
            #1;
            n++;
            if (n >= 20) report_timeout("ack did not fall after req release");
        end
    endtask

    task model_step(input logic [31:0] w);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] pc4;
        logic [31:0] res;
        logic [31:0] addr;
        logic [7:0]  ld_byte;
        logic        wr;
        rs      = w[25:21];
        rt      = w[20:16];
        a       = m_regs[rs];
        b       = m_regs[rt];
        sx      = {{16{w[15]}}, w[15:0]};
        zx      = {16'h0000, w[15:0]};
        pc4     = m_pc + 32'd4;
        addr    = a + sx;
        ld_byte = m_mem[addr[7:2]][{addr[1:0], 3'b000} +: 8];
        exp_next_pc  = pc4;
        exp_store_en = 1'b0;
        wr  = 1'b1;
        dst = rt;
        res = '0;
        case (w[31:26])
            6'h00: begin
                dst = w[15:11];
                case (w[5:0])
                    6'h20, 6'h21: res = a + b;
                    6'h22: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h2a: res = {31'b0, $signed(a) < $signed(b)};
                    6'h00: res = b << w[10:6];
                    6'h02: res = b >> w[10:6];
                    6'h03: res = $signed(b) >>> w[10:6];
                    default: begin // jr
                        wr          = 1'b0;
                        exp_next_pc = a;
                    end
                endcase
            end
            6'h08: res = a + sx;
            6'h09: res = a + zx;   // ADDiu zero-extends
            6'h0c: res = a & zx;
            6'h0d: res = a | zx;
            6'h0e: res = a ^ zx;
            6'h0a: res = {31'b0, $signed(a) < $signed(sx)};
            6'h0f: res = {w[15:0], 16'h0000};
            6'h23: res = m_mem[addr[7:2]];
            6'h20: res = {{24{ld_byte[7]}}, ld_byte};
            6'h02, 6'h03: begin
                wr          = (w[31:26] == 6'h03);
                dst         = 5'd31;
                res         = pc4;
                exp_next_pc = {pc4[31:28], w[25:0], 2'b00};
            end
            6'h2b, 6'h28: begin
                wr           = 1'b0;
                exp_store_en = 1'b1;
                if (w[31:26] == 6'h2b) m_mem[addr[7:2]] = b;
                else m_mem[addr[7:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
            end
            default: begin // Branches
                wr = 1'b0;
                if ((w[31:26] == 6'h04 && a == b) || (w[31:26] == 6'h05 && a != b) ||
                    (w[31:26] == 6'h06 && $signed(a) <= 0) ||
                    (w[31:26] == 6'h07 && $signed(a) > 0) ||
                    (w[31:26] == 6'h01 && !a[31])) begin
                    exp_next_pc = pc4 + {sx[29:0], 2'b00};
                end
            end
        endcase
        exp_store_addr = addr;
        exp_store_data = b;
        exp_wb_en      = wr && (dst != 5'd0);
        exp_wb_reg     = dst;
        exp_wb_data    = res;
        if (exp_wb_en) m_regs[dst] = res;
        m_pc = exp_next_pc;
    endtask

    task compare_outputs(input string name);
        check(wb_en, exp_wb_en, {name, " wb_en"});
        if (exp_wb_en) begin
            check(wb_reg, exp_wb_reg, {name, " wb_reg"});
            check(wb_data, exp_wb_data, {name, " wb_data"});
        end
        check(store_en, exp_store_en, {name, " store_en"});
        if (exp_store_en) begin
            check(store_addr, exp_store_addr, {name, " store_addr"});
            check(store_data, exp_store_data, {name, " store_data"});
        end
        check(next_pc, exp_next_pc, {name, " next_pc"});
    endtask

    task run_instr(input logic [31:0] w, input string name);
        model_step(w);
        send_instr(w, 0);
        compare_outputs(name);
    endtask

    `include "tb_mips_tests.svh"

    initial begin
        rst   = 1'b1;
        req   = 1'b0;
        instr = '0;
        foreach (m_regs[i]) m_regs[i] = '0;
        m_pc = `MIPS_RESET_PC;
        void'($urandom(32'h2121_7ac2));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        handshake_test();
        imm_ops_test();
        rtype_test();
        memory_test();
        branch_test();
        jump_test();
        $display("No errors");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hw
+incdir+testbench
hw/mips_pkg.sv
hw/stage_if.sv
hw/control.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/mips_exec_top.sv
testbench/tb_mips_exec.sv
